// File: hdl/rv32_consts.svh
/* Widths, reset PC, opcodes, funct codes and the datapath select
   encodings for the RV32I core */
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

`define RV32_XLEN        32
`define RV32_REG_ADDR_W  5
`define RV32_RESET_PC    32'h0000_0000

`define RV32_OP_LUI      7'b01_101_11
`define RV32_OP_AUIPC    7'b00_101_11
`define RV32_OP_JAL      7'b11_011_11
`define RV32_OP_JALR     7'b11_001_11
`define RV32_OP_BRANCH   7'b11_000_11
`define RV32_OP_LOAD     7'b00_000_11
`define RV32_OP_STORE    7'b01_000_11
`define RV32_OP_IMM      7'b00_100_11
`define RV32_OP_OP       7'b01_100_11

// Branch conditions
`define RV32_F3_BEQ      3'b000
`define RV32_F3_BNE      3'b001
`define RV32_F3_BLT      3'b100
`define RV32_F3_BGE      3'b101
`define RV32_F3_BLTU     3'b110
`define RV32_F3_BGEU     3'b111

// Access sizes, shared by loads and stores
`define RV32_F3_B        3'b000
`define RV32_F3_H        3'b001
`define RV32_F3_W        3'b010
`define RV32_F3_BU       3'b100
`define RV32_F3_HU       3'b101

`define RV32_F3_ADD      3'b000
`define RV32_F3_SLL      3'b001
`define RV32_F3_SLT      3'b010
`define RV32_F3_SLTU     3'b011
`define RV32_F3_XOR      3'b100
`define RV32_F3_SR       3'b101
`define RV32_F3_OR       3'b110
`define RV32_F3_AND      3'b111

`define RV32_F7_BASE     7'b0000000
`define RV32_F7_ALT      7'b0100000

`define RV32_IMM_I       3'd0
`define RV32_IMM_S       3'd1
`define RV32_IMM_B       3'd2
`define RV32_IMM_U       3'd3
`define RV32_IMM_J       3'd4

`define RV32_WB_ALU      3'd0
`define RV32_WB_LUI      3'd1
`define RV32_WB_PC_IMM   3'd2
`define RV32_WB_PC4      3'd3
`define RV32_WB_LOAD     3'd4

`define RV32_MEM_NONE    2'b00
`define RV32_MEM_LOAD    2'b01
`define RV32_MEM_STORE   2'b10

`endif

// File: hdl/rv32_pkg.sv
/* Shared types of the RV32I core: data words, register indices,
   byte masks, funct3 field, ALU operations and run state */
`include "rv32_consts.svh"

package rv32_pkg;

	typedef logic [`RV32_XLEN-1:0]       word_t;
	typedef logic [`RV32_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`RV32_XLEN/8-1:0]     strb_t;  // One bit per byte lane
	typedef logic [2:0]                  funct3_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_or,
		alu_and
	} alu_op_t;

	typedef enum logic {
		st_run,
		st_halted  // Left only by reset
	} core_state_t;

endpackage

// File: hdl/rv32_imm_gen.sv
/* Immediate generator for the I, S, B, U and J formats */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_imm_gen (
	input  rv32_pkg::word_t insn,
	input  logic [2:0]      imm_sel,
	output rv32_pkg::word_t imm
);

	always_comb begin
		case (imm_sel)
			`RV32_IMM_S: begin
				imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
			end
			`RV32_IMM_B: begin
				imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
			end
			`RV32_IMM_U: begin
				imm = {insn[31:12], 12'b0};
			end
			`RV32_IMM_J: begin
				imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
			end
			default: begin
				imm = {{20{insn[31]}}, insn[31:20]};  // I format
			end
		endcase
	end

endmodule

// File: hdl/rv32_decoder.sv
/* Instruction decoder with datapath selects, handshake gating
   and the run/halted state machine */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_decoder (
	input  logic                clk,
	input  logic                arst_n,
	input  rv32_pkg::word_t     insn,
	input  logic                insn_valid,
	input  logic                mem_ready,
	output rv32_pkg::reg_addr_t rs1_idx,
	output rv32_pkg::reg_addr_t rs2_idx,
	output rv32_pkg::reg_addr_t rd_idx,
	output logic                rd_we,
	output rv32_pkg::alu_op_t   alu_op,
	output logic                use_imm,
	output logic [2:0]          imm_sel,
	output logic [2:0]          wb_sel,
	output logic [1:0]          mem_req,
	output rv32_pkg::funct3_t   mem_funct3,
	output logic                branch,
	output logic                jump,
	output logic                jump_reg,
	output logic                complete,
	output logic                trap
);

	logic [6:0]            opcode;
	rv32_pkg::funct3_t     f3;
	logic [6:0]            f7;
	logic                  legal;
	logic                  is_imm_op;
	logic                  writes_rd;
	logic [1:0]            mem_kind;
	logic                  running;
	logic                  accept;
	rv32_pkg::core_state_t state;

	assign opcode     = insn[6:0];
	assign f3         = insn[14:12];
	assign f7         = insn[31:25];
	assign rd_idx     = insn[11:7];
	assign rs1_idx    = insn[19:15];
	assign rs2_idx    = insn[24:20];
	assign mem_funct3 = f3;  // Also selects the branch condition
	assign is_imm_op  = (opcode == `RV32_OP_IMM);

	always_comb begin
		legal     = 1'b0;
		writes_rd = 1'b0;
		alu_op    = rv32_pkg::alu_add;
		use_imm   = 1'b1;
		imm_sel   = `RV32_IMM_I;
		wb_sel    = `RV32_WB_ALU;
		mem_kind  = `RV32_MEM_NONE;
		branch    = 1'b0;
		jump      = 1'b0;
		jump_reg  = 1'b0;
		case (opcode)
			`RV32_OP_LUI: begin
				legal     = 1'b1;
				writes_rd = 1'b1;
				imm_sel   = `RV32_IMM_U;
				wb_sel    = `RV32_WB_LUI;
			end
			`RV32_OP_AUIPC: begin
				legal     = 1'b1;
				writes_rd = 1'b1;
				imm_sel   = `RV32_IMM_U;
				wb_sel    = `RV32_WB_PC_IMM;
			end
			`RV32_OP_JAL: begin
				legal     = 1'b1;
				writes_rd = 1'b1;
				imm_sel   = `RV32_IMM_J;
				wb_sel    = `RV32_WB_PC4;
				jump      = 1'b1;
			end
			`RV32_OP_JALR: begin
				legal     = (f3 == 3'b000);
				writes_rd = 1'b1;
				wb_sel    = `RV32_WB_PC4;
				jump_reg  = 1'b1;  // Target is rs1 + imm from the ALU
			end
			`RV32_OP_BRANCH: begin
				legal   = (f3 != 3'b010) && (f3 != 3'b011);
				use_imm = 1'b0;  // Compare rs1 against rs2
				imm_sel = `RV32_IMM_B;
				branch  = 1'b1;
			end
			`RV32_OP_LOAD: begin
				legal     = (f3 == `RV32_F3_B) || (f3 == `RV32_F3_H) || (f3 == `RV32_F3_W)
				         || (f3 == `RV32_F3_BU) || (f3 == `RV32_F3_HU);
				writes_rd = 1'b1;
				wb_sel    = `RV32_WB_LOAD;
				mem_kind  = `RV32_MEM_LOAD;
			end
			`RV32_OP_STORE: begin
				legal    = (f3 == `RV32_F3_B) || (f3 == `RV32_F3_H) || (f3 == `RV32_F3_W);
				imm_sel  = `RV32_IMM_S;
				mem_kind = `RV32_MEM_STORE;
			end
			`RV32_OP_IMM, `RV32_OP_OP: begin
				writes_rd = 1'b1;
				use_imm   = is_imm_op;
				case (f3)
					`RV32_F3_ADD: begin
						legal = is_imm_op || (f7 == `RV32_F7_BASE) || (f7 == `RV32_F7_ALT);
						if (!is_imm_op && f7 == `RV32_F7_ALT) begin
							alu_op = rv32_pkg::alu_sub;
						end
					end
					`RV32_F3_SLL: begin
						legal  = (f7 == `RV32_F7_BASE);
						alu_op = rv32_pkg::alu_sll;
					end
					`RV32_F3_SR: begin
						legal  = (f7 == `RV32_F7_BASE) || (f7 == `RV32_F7_ALT);
						alu_op = (f7 == `RV32_F7_ALT) ? rv32_pkg::alu_sra : rv32_pkg::alu_srl;
					end
					default: begin
						// Immediate forms carry imm bits where funct7 would be
						legal = is_imm_op || (f7 == `RV32_F7_BASE);
						case (f3)
							`RV32_F3_SLT:  alu_op = rv32_pkg::alu_slt;
							`RV32_F3_SLTU: alu_op = rv32_pkg::alu_sltu;
							`RV32_F3_XOR:  alu_op = rv32_pkg::alu_xor;
							`RV32_F3_OR:   alu_op = rv32_pkg::alu_or;
							default:       alu_op = rv32_pkg::alu_and;
						endcase
					end
				endcase
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign running  = (state == rv32_pkg::st_run);
	assign accept   = insn_valid && running && legal;
	assign mem_req  = accept ? mem_kind : `RV32_MEM_NONE;
	assign complete = accept && ((mem_kind == `RV32_MEM_NONE) || mem_ready);
	assign rd_we    = complete && writes_rd;
	assign trap     = !running || (insn_valid && !legal);  // Sticky once halted

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= rv32_pkg::st_run;
		end else if (running && insn_valid && !legal) begin
			state <= rv32_pkg::st_halted;
		end
	end

endmodule

// File: hdl/rv32_alu.sv
/* ALU with add/sub, logic, shifts, set-less-than and the six
   branch conditions */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_alu (
	input  rv32_pkg::alu_op_t op,
	input  rv32_pkg::word_t   a,
	input  rv32_pkg::word_t   b,
	input  rv32_pkg::funct3_t funct3,
	output rv32_pkg::word_t   result,
	output logic              branch_taken
);

	logic [4:0] shamt;
	logic       lt;
	logic       ltu;

	assign shamt = b[4:0];
	assign lt    = $signed(a) < $signed(b);
	assign ltu   = a < b;

	always_comb begin
		case (op)
			rv32_pkg::alu_sub:  result = a - b;
			rv32_pkg::alu_sll:  result = a << shamt;
			rv32_pkg::alu_srl:  result = a >> shamt;
			rv32_pkg::alu_sra:  result = rv32_pkg::word_t'($signed(a) >>> shamt);
			rv32_pkg::alu_slt:  result = rv32_pkg::word_t'(lt);
			rv32_pkg::alu_sltu: result = rv32_pkg::word_t'(ltu);  // Imm is sign extended first
			rv32_pkg::alu_xor:  result = a ^ b;
			rv32_pkg::alu_or:   result = a | b;
			rv32_pkg::alu_and:  result = a & b;
			default:            result = a + b;
		endcase
	end

	always_comb begin
		case (funct3)
			`RV32_F3_BEQ:  branch_taken = (a == b);
			`RV32_F3_BNE:  branch_taken = (a != b);
			`RV32_F3_BLT:  branch_taken = lt;
			`RV32_F3_BGE:  branch_taken = !lt;
			`RV32_F3_BLTU: branch_taken = ltu;
			`RV32_F3_BGEU: branch_taken = !ltu;
			default:       branch_taken = 1'b0;  // Undecodable, trapped elsewhere
		endcase
	end

endmodule

// File: hdl/rv32_regfile.sv
/* Register file with x1..x31, two combinational read ports and
   one write port */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_regfile (
	input  logic                clk,
	input  logic                arst_n,
	input  rv32_pkg::reg_addr_t rs1_idx,
	input  rv32_pkg::reg_addr_t rs2_idx,
	output rv32_pkg::word_t     rs1_data,
	output rv32_pkg::word_t     rs2_data,
	input  rv32_pkg::reg_addr_t rd_idx,
	input  logic                rd_we,
	input  rv32_pkg::word_t     rd_data
);

	rv32_pkg::word_t regs [1:(1 << `RV32_REG_ADDR_W) - 1];  // x0 has no storage

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < (1 << `RV32_REG_ADDR_W); i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd_idx != '0) begin
			regs[rd_idx] <= rd_data;
		end
	end

	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// File: hdl/rv32_lsu.sv
/* Load/store unit: request fields at byte lane 0 and load
   sign/zero extension */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_lsu (
	input  logic [1:0]        mem_req,
	input  rv32_pkg::funct3_t funct3,
	input  rv32_pkg::word_t   addr,
	input  rv32_pkg::word_t   store_data,
	output logic              mem_valid,
	output rv32_pkg::word_t   mem_addr,
	output rv32_pkg::word_t   mem_wdata,
	output rv32_pkg::strb_t   mem_wstrb,
	output rv32_pkg::strb_t   mem_rmask,
	input  rv32_pkg::word_t   mem_rdata,
	output rv32_pkg::word_t   load_data
);

	logic            is_load;
	logic            is_store;
	rv32_pkg::strb_t lanes;

	assign is_load  = (mem_req == `RV32_MEM_LOAD);
	assign is_store = (mem_req == `RV32_MEM_STORE);

	always_comb begin
		case (funct3)
			`RV32_F3_B, `RV32_F3_BU: lanes = 4'b0001;
			`RV32_F3_H, `RV32_F3_HU: lanes = 4'b0011;
			`RV32_F3_W:              lanes = 4'b1111;
			default:                 lanes = 4'b0000;
		endcase
	end

	assign mem_valid = is_load || is_store;
	assign mem_addr  = mem_valid ? addr : '0;  // Full byte address, no lane shift
	assign mem_wdata = is_store ? store_data : '0;
	assign mem_wstrb = is_store ? lanes : '0;
	assign mem_rmask = is_load ? lanes : '0;

	always_comb begin
		case (funct3)
			`RV32_F3_B:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			`RV32_F3_BU: load_data = {24'b0, mem_rdata[7:0]};
			`RV32_F3_H:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			`RV32_F3_HU: load_data = {16'b0, mem_rdata[15:0]};
			default:     load_data = mem_rdata;
		endcase
	end

endmodule

// File: hdl/rv32_core.sv
/* RV32I core top: PC register, next-PC and write-back selection,
   decoder, immediates, ALU, register file and LSU */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_core (
	input  logic            clk,
	input  logic            arst_n,
	output rv32_pkg::word_t insn_addr,
	input  rv32_pkg::word_t insn,
	input  logic            insn_valid,
	output logic            insn_complete,
	output logic            trap,
	output logic            mem_valid,
	input  logic            mem_ready,
	output rv32_pkg::word_t mem_addr,
	output rv32_pkg::word_t mem_wdata,
	output rv32_pkg::strb_t mem_wstrb,
	output rv32_pkg::strb_t mem_rmask,
	input  rv32_pkg::word_t mem_rdata
);

	rv32_pkg::word_t     pc;
	rv32_pkg::word_t     pc_next;
	rv32_pkg::word_t     pc_plus4;
	rv32_pkg::word_t     pc_plus_imm;
	rv32_pkg::word_t     imm;
	rv32_pkg::word_t     rs1_data;
	rv32_pkg::word_t     rs2_data;
	rv32_pkg::word_t     alu_b;
	rv32_pkg::word_t     alu_result;
	rv32_pkg::word_t     load_data;
	rv32_pkg::word_t     rd_data;
	rv32_pkg::reg_addr_t rs1_idx;
	rv32_pkg::reg_addr_t rs2_idx;
	rv32_pkg::reg_addr_t rd_idx;
	rv32_pkg::alu_op_t   alu_op;
	rv32_pkg::funct3_t   mem_funct3;
	logic                rd_we;
	logic                use_imm;
	logic [2:0]          imm_sel;
	logic [2:0]          wb_sel;
	logic [1:0]          mem_req;
	logic                branch;
	logic                jump;
	logic                jump_reg;
	logic                branch_taken;

	rv32_decoder rv32_decoder_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.insn       (insn),
		.insn_valid (insn_valid),
		.mem_ready  (mem_ready),
		.rs1_idx    (rs1_idx),
		.rs2_idx    (rs2_idx),
		.rd_idx     (rd_idx),
		.rd_we      (rd_we),
		.alu_op     (alu_op),
		.use_imm    (use_imm),
		.imm_sel    (imm_sel),
		.wb_sel     (wb_sel),
		.mem_req    (mem_req),
		.mem_funct3 (mem_funct3),
		.branch     (branch),
		.jump       (jump),
		.jump_reg   (jump_reg),
		.complete   (insn_complete),
		.trap       (trap)
	);

	rv32_imm_gen rv32_imm_gen_i (
		.insn    (insn),
		.imm_sel (imm_sel),
		.imm     (imm)
	);

	assign alu_b = use_imm ? imm : rs2_data;

	rv32_alu rv32_alu_i (
		.op           (alu_op),
		.a            (rs1_data),
		.b            (alu_b),
		.funct3       (mem_funct3),
		.result       (alu_result),
		.branch_taken (branch_taken)
	);

	rv32_regfile rv32_regfile_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.rd_idx   (rd_idx),
		.rd_we    (rd_we),
		.rd_data  (rd_data)
	);

	rv32_lsu rv32_lsu_i (
		.mem_req    (mem_req),
		.funct3     (mem_funct3),
		.addr       (alu_result),  // rs1 + I or S immediate
		.store_data (rs2_data),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wstrb  (mem_wstrb),
		.mem_rmask  (mem_rmask),
		.mem_rdata  (mem_rdata),
		.load_data  (load_data)
	);

	assign insn_addr   = pc;
	assign pc_plus4    = pc + rv32_pkg::word_t'(4);
	assign pc_plus_imm = pc + imm;  // Branch, JAL and AUIPC share this adder

	always_comb begin
		if (jump_reg) begin
			pc_next = {alu_result[31:1], 1'b0};
		end else if (jump || (branch && branch_taken)) begin
			pc_next = pc_plus_imm;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_comb begin
		case (wb_sel)
			`RV32_WB_LUI:    rd_data = imm;
			`RV32_WB_PC_IMM: rd_data = pc_plus_imm;
			`RV32_WB_PC4:    rd_data = pc_plus4;  // Link address
			`RV32_WB_LOAD:   rd_data = load_data;
			default:         rd_data = alu_result;
		endcase
	end

	// PC holds on stalls and stays frozen after a trap
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `RV32_RESET_PC;
		end else if (insn_complete) begin
			pc <= pc_next;
		end
	end

endmodule

// File: verif/rv32_properties.sv
/* Concurrent assertions on the memory handshake, the store/load mask exclusivity
   and the frozen state after a trap */
`timescale 1ns/1ps

module rv32_properties (
	input logic            clk,
	input logic            arst_n,
	input rv32_pkg::word_t insn_addr,
	input logic            insn_complete,
	input logic            trap,
	input logic            mem_valid,
	input logic            mem_ready,
	input rv32_pkg::word_t mem_addr,
	input rv32_pkg::word_t mem_wdata,
	input rv32_pkg::strb_t mem_wstrb,
	input rv32_pkg::strb_t mem_rmask
);

	// A stalled request keeps all of its fields
	req_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr) && $stable(mem_wdata)
			&& $stable(mem_wstrb) && $stable(mem_rmask)))
		else $error("memory request changed while stalled");

	masks_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!((|mem_wstrb) && (|mem_rmask)))
		else $error("store strobes and load mask both set");

	trap_frozen: assert property (@(posedge clk) disable iff (!arst_n)
		trap |=> (trap && $stable(insn_addr) && !insn_complete))
		else $error("core moved after a trap");

endmodule

// File: verif/rv32_tb.sv
/* Testbench for the RV32I core: clock, memory models, ISA reference model,
   program builders and the compare process */
`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_tb;

	logic            clk;
	logic            arst_n;
	rv32_pkg::word_t insn_addr;
	rv32_pkg::word_t insn;
	logic            insn_valid;
	logic            insn_complete;
	logic            trap;
	logic            mem_valid;
	logic            mem_ready;
	rv32_pkg::word_t mem_addr;
	rv32_pkg::word_t mem_wdata;
	rv32_pkg::strb_t mem_wstrb;
	rv32_pkg::strb_t mem_rmask;
	rv32_pkg::word_t mem_rdata;

	logic [31:0] imem [0:255];
	logic [7:0]  dmem [0:1023];
	logic [7:0]  ref_mem [0:1023];  // Shadow data memory of the model
	logic [31:0] ref_regs [0:31];
	logic [31:0] ref_pc;
	logic [31:0] exp_next_pc;
	logic [31:0] exp_addr;
	logic [31:0] exp_data;
	logic [3:0]  exp_strb;
	logic [3:0]  exp_rmask;
	logic        exp_store;
	logic        exp_load;
	logic        exp_trap;
	logic        pc_pending;
	logic        rand_ready;
	integer      seed = 41;
	integer      ppos;
	integer      checks;
	integer      errors;
	integer      test_errors;
	integer      ref_stores;
	integer      dut_stores;
	integer      tests_run;
	integer      tests_failed;

	rv32_core rv32_core_i (.*);

	bind rv32_core rv32_properties rv32_properties_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	assign insn      = imem[insn_addr[9:2]];
	assign mem_rdata = {dmem[mem_addr[9:0] + 10'd3], dmem[mem_addr[9:0] + 10'd2],
		dmem[mem_addr[9:0] + 10'd1], dmem[mem_addr[9:0]]};  // Low lanes from the byte address

	always @(posedge clk) begin
		if (mem_valid && mem_ready && mem_wstrb != 4'b0) begin
			dut_stores = dut_stores + 1;
			for (int i = 0; i < 4; i++) begin
				if (mem_wstrb[i]) dmem[mem_addr[9:0] + 10'(i)] = mem_wdata[8*i +: 8];
			end
		end
		#1;
		mem_ready <= rand_ready ? 1'($random(seed)) : 1'b1;
	end

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// ISA reference: one instruction on the shadow state
	function void ref_execute(input logic [31:0] w);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immi;
		logic [31:0] imms;
		logic [31:0] res;
		logic        wr;
		logic        taken;
		rd   = w[11:7];
		f3   = w[14:12];
		a    = ref_regs[w[19:15]];
		b    = ref_regs[w[24:20]];
		immi = {{20{w[31]}}, w[31:20]};
		imms = {{20{w[31]}}, w[31:25], w[11:7]};
		res  = 32'b0;
		wr   = 1'b0;
		taken = 1'b0;
		exp_next_pc = ref_pc + 32'd4;
		exp_store   = 1'b0;
		exp_load    = 1'b0;
		exp_trap    = 1'b0;
		case (w[6:0])
			`RV32_OP_LUI: begin
				res = {w[31:12], 12'b0};
				wr  = 1'b1;
			end
			`RV32_OP_AUIPC: begin
				res = ref_pc + {w[31:12], 12'b0};
				wr  = 1'b1;
			end
			`RV32_OP_JAL: begin
				res = ref_pc + 32'd4;
				wr  = 1'b1;
				exp_next_pc = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			`RV32_OP_JALR: begin
				res = ref_pc + 32'd4;
				wr  = 1'b1;
				exp_next_pc = (a + immi) & ~32'd1;
				exp_trap = (f3 != 3'd0);
			end
			`RV32_OP_BRANCH: begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = $signed(a) < $signed(b);
					3'd5: taken = $signed(a) >= $signed(b);
					3'd6: taken = a < b;
					3'd7: taken = a >= b;
					default: exp_trap = 1'b1;
				endcase
				if (taken) exp_next_pc = ref_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			`RV32_OP_LOAD: begin
				exp_load  = 1'b1;
				exp_addr  = a + immi;
				exp_rmask = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
				res = {ref_mem[exp_addr[9:0] + 10'd3], ref_mem[exp_addr[9:0] + 10'd2],
					ref_mem[exp_addr[9:0] + 10'd1], ref_mem[exp_addr[9:0]]};
				wr  = 1'b1;
				case (f3)
					3'd0: res = {{24{res[7]}}, res[7:0]};
					3'd1: res = {{16{res[15]}}, res[15:0]};
					3'd4: res = {24'b0, res[7:0]};
					3'd5: res = {16'b0, res[15:0]};
					3'd2: res = res;
					default: exp_trap = 1'b1;
				endcase
			end
			`RV32_OP_STORE: begin
				exp_store = 1'b1;
				exp_addr  = a + imms;
				exp_data  = b;
				exp_strb  = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
				exp_trap  = (f3 > 3'd2);
			end
			`RV32_OP_IMM: begin
				res = alu_ref(f3, (f3 == 3'd5) && w[30], a, immi);
				wr  = 1'b1;
			end
			`RV32_OP_OP: begin
				res = alu_ref(f3, w[30], a, b);
				wr  = 1'b1;
			end
			default: exp_trap = 1'b1;
		endcase
		if (!exp_trap) begin
			if (wr && rd != 5'd0) ref_regs[rd] = res;
			if (exp_store) begin
				ref_stores = ref_stores + 1;
				for (int i = 0; i < 4; i++) begin
					if (exp_strb[i]) ref_mem[exp_addr[9:0] + 10'(i)] = exp_data[8*i +: 8];
				end
			end
			ref_pc = exp_next_pc;
		end
	endfunction

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors = errors + 1;
	endtask

	// Compare process, sampled at the falling edge where all outputs are settled
	always @(negedge clk) begin
		if (arst_n) begin
			if (pc_pending) begin
				checks = checks + 1;
				assert (insn_addr == exp_next_pc) else
					report_mismatch($sformatf("next pc %h, expected %h", insn_addr, exp_next_pc));
				pc_pending = 1'b0;
			end
			if (insn_complete) begin
				ref_execute(insn);
				checks = checks + 1;
				assert (!exp_trap) else report_mismatch("completed an illegal instruction");
				if (exp_store) begin
					assert (mem_valid && mem_addr == exp_addr && mem_wstrb == exp_strb
						&& (mem_wdata & lane_mask(exp_strb)) == (exp_data & lane_mask(exp_strb)))
					else report_mismatch($sformatf("store @%h data %h strb %b, expected @%h %h %b",
						mem_addr, mem_wdata, mem_wstrb, exp_addr, exp_data, exp_strb));
				end else begin
					assert (mem_wstrb == 4'b0) else report_mismatch("unexpected store strobes");
				end
				if (exp_load) begin
					assert (mem_valid && mem_addr == exp_addr && mem_rmask == exp_rmask)
					else report_mismatch($sformatf("load @%h rmask %b, expected @%h %b",
						mem_addr, mem_rmask, exp_addr, exp_rmask));
				end else begin
					assert (mem_rmask == 4'b0) else report_mismatch("unexpected load mask");
				end
				pc_pending = 1'b1;
			end
		end
	end

	function automatic logic [31:0] lane_mask(input logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `RV32_OP_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], `RV32_OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV32_OP_BRANCH};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[ppos] = w;
		ppos = ppos + 1;
	endtask

	task automatic emit_sw(input logic [4:0] rs2);
		emit(enc_s(12'h200, rs2, 3'b010));
	endtask

	task automatic clear_program();
		for (int i = 0; i < 256; i++) imem[i] = 32'h0;  // Zero word is an illegal opcode
		ppos = 0;
	endtask

	task automatic build_alu_program();
		logic [31:0] v;
		clear_program();
		for (int k = 1; k <= 4; k++) begin
			v = $random(seed);
			emit({v[31:12], 5'(k), `RV32_OP_LUI});
			emit(enc_i(v[11:0], 5'(k), 3'd0, 5'(k), `RV32_OP_IMM));
		end
		for (int f = 0; f < 8; f++) begin
			emit(enc_r(`RV32_F7_BASE, 5'd2, 5'd1, 3'(f), 5'd5));
			emit_sw(5'd5);
			emit(enc_r(`RV32_F7_BASE, 5'd4, 5'd3, 3'(f), 5'd5));
			emit_sw(5'd5);
		end
		emit(enc_r(`RV32_F7_ALT, 5'd2, 5'd1, 3'd0, 5'd5));  // sub
		emit_sw(5'd5);
		emit(enc_r(`RV32_F7_ALT, 5'd4, 5'd3, 3'd5, 5'd5));  // sra
		emit_sw(5'd5);
		for (int f = 0; f < 8; f++) begin
			v = $random(seed);
			if (f == 1 || f == 5) v[11:5] = 7'd0;
			emit(enc_i(v[11:0], 5'd3, 3'(f), 5'd6, `RV32_OP_IMM));
			emit_sw(5'd6);
		end
		emit(enc_i({7'b0100000, 5'd13}, 5'd3, 3'd5, 5'd6, `RV32_OP_IMM));  // srai
		emit_sw(5'd6);
		emit(enc_r(`RV32_F7_BASE, 5'd2, 5'd1, 3'd0, 5'd0));  // Result into x0
		emit_sw(5'd0);
	endtask

	task automatic build_branch_program();
		logic [2:0] kinds [6];
		kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		clear_program();
		emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, `RV32_OP_IMM));
		emit(enc_i(-12'sd3, 5'd0, 3'd0, 5'd2, `RV32_OP_IMM));
		emit(enc_i(12'd5, 5'd0, 3'd0, 5'd3, `RV32_OP_IMM));
		foreach (kinds[k]) begin
			emit(enc_b(13'd8, 5'd2, 5'd1, kinds[k]));
			emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, `RV32_OP_IMM));
			emit(enc_b(13'd8, 5'd3, 5'd1, kinds[k]));
			emit(enc_i(12'd2, 5'd6, 3'd0, 5'd6, `RV32_OP_IMM));
			emit(enc_b(13'd8, 5'd1, 5'd2, kinds[k]));  // Negative against positive
			emit(enc_i(12'd4, 5'd6, 3'd0, 5'd6, `RV32_OP_IMM));
			emit_sw(5'd6);
		end
		emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd7, `RV32_OP_JAL});  // jal x7, +8
		emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, `RV32_OP_IMM));
		emit_sw(5'd7);
		emit({20'd0, 5'd8, `RV32_OP_AUIPC});
		emit(enc_i(12'd17, 5'd8, 3'd0, 5'd9, `RV32_OP_JALR));  // Odd target, bit 0 dropped
		emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, `RV32_OP_IMM));
		emit(enc_i(12'd1, 5'd6, 3'd0, 5'd6, `RV32_OP_IMM));
		emit_sw(5'd9);
		emit_sw(5'd6);
	endtask

	task automatic build_load_program();
		logic [11:0] addrs [5];
		addrs = '{12'h0F1, 12'h1FA, 12'h010, 12'h3E2, 12'h3FC};  // First two hold negative bytes
		clear_program();
		foreach (addrs[k]) begin
			for (int f = 0; f < 6; f++) begin
				if (f != 3) begin
					emit(enc_i(addrs[k], 5'd0, 3'(f), 5'd5, `RV32_OP_LOAD));
					emit_sw(5'd5);
				end
			end
		end
		emit(enc_i(12'h3F4, 5'd0, 3'd2, 5'd1, `RV32_OP_LOAD));
		emit(enc_s(12'h210, 5'd1, 3'b000));  // sb
		emit(enc_s(12'h214, 5'd1, 3'b001));  // sh
		emit(enc_i(12'h210, 5'd0, 3'd2, 5'd6, `RV32_OP_LOAD));
		emit_sw(5'd6);
	endtask

	task automatic apply_reset();
		arst_n     = 1'b0;
		insn_valid = 1'b0;
		pc_pending = 1'b0;
		ref_pc     = `RV32_RESET_PC;
		ref_stores = 0;
		dut_stores = 0;
		for (int i = 0; i < 32; i++) ref_regs[i] = 32'b0;
		for (int i = 0; i < 1024; i++) begin
			dmem[i]    = 8'(i) ^ {4{2'(i >> 8)}};
			ref_mem[i] = dmem[i];
		end
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		checks = checks + 1;
		assert (insn_addr == `RV32_RESET_PC && !mem_valid && !insn_complete && !trap) else
			report_mismatch($sformatf("after reset pc %h mem_valid %b", insn_addr, mem_valid));
		@(posedge clk);
		#1;
		insn_valid = 1'b1;
	endtask

	task automatic run_test(input string name, input logic random_ready);
		integer     cycles;
		logic [31:0] trap_pc;
		test_errors = errors;
		rand_ready  = random_ready;
		apply_reset();
		cycles = 0;
		while (!trap && cycles < 5000) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		if (!trap) begin
			$display("Timeout: the core never reached the closing illegal instruction in %s", name);
			$display("Something failed");
			$finish;
		end
		@(negedge clk);
		trap_pc = insn_addr;
		ref_execute(insn);
		checks = checks + 1;
		assert (exp_trap && trap_pc == ref_pc) else
			report_mismatch($sformatf("trap at pc %h, model pc %h", trap_pc, ref_pc));
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			checks = checks + 1;
			assert (insn_addr == trap_pc && !insn_complete && trap) else
				report_mismatch("core left the trapped state");
		end
		checks = checks + 1;
		assert (dut_stores == ref_stores) else
			report_mismatch($sformatf("%0d stores seen, %0d expected", dut_stores, ref_stores));
		tests_run = tests_run + 1;
		if (errors != test_errors) tests_failed = tests_failed + 1;
		$display("%s: %0d errors", name, errors - test_errors);
	endtask

	initial begin
		arst_n       = 1'b0;
		insn_valid   = 1'b0;
		mem_ready    = 1'b1;
		rand_ready   = 1'b0;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		build_alu_program();
		run_test("alu", 1'b0);
		build_branch_program();
		run_test("control flow", 1'b0);
		build_load_program();
		run_test("loads and narrow stores", 1'b0);
		build_alu_program();
		run_test("back-pressure", 1'b1);
		clear_program();
		emit(enc_i(12'd7, 5'd0, 3'd0, 5'd1, `RV32_OP_IMM));
		emit(32'hFFFF_FFFF);
		run_test("reset and trap", 1'b0);
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+hdl
hdl/rv32_pkg.sv
hdl/rv32_imm_gen.sv
hdl/rv32_decoder.sv
hdl/rv32_alu.sv
hdl/rv32_regfile.sv
hdl/rv32_lsu.sv
hdl/rv32_core.sv
verif/rv32_properties.sv
verif/rv32_tb.sv

// File: Bender.yml
package:
  name: rv32_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv32_pkg.sv
      - hdl/rv32_imm_gen.sv
      - hdl/rv32_decoder.sv
      - hdl/rv32_alu.sv
      - hdl/rv32_regfile.sv
      - hdl/rv32_lsu.sv
      - hdl/rv32_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/rv32_properties.sv
      - verif/rv32_tb.sv
